/* verilog/isa_pkg.sv */
package isa_pkg;

    // machine word and register index
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_idx_t;

    // alu ops follow {funct7[5], funct3} so the decoder can pass funct fields through
    typedef enum logic [3:0] {
        alu_add    = 4'b0000,
        alu_sll    = 4'b0001,
        alu_slt    = 4'b0010,
        alu_sltu   = 4'b0011,
        alu_xor    = 4'b0100,
        alu_srl    = 4'b0101,
        alu_or     = 4'b0110,
        alu_and    = 4'b0111,
        alu_sub    = 4'b1000,
        alu_sra    = 4'b1101,
        alu_pass_b = 4'b1111
    } alu_op_e;

    // major opcodes
    localparam logic [6:0] opc_op       = 7'b0110011;
    localparam logic [6:0] opc_op_imm   = 7'b0010011;
    localparam logic [6:0] opc_lui      = 7'b0110111;
    localparam logic [6:0] opc_auipc    = 7'b0010111;
    localparam logic [6:0] opc_jal      = 7'b1101111;
    localparam logic [6:0] opc_jalr     = 7'b1100111;
    localparam logic [6:0] opc_branch   = 7'b1100011;
    localparam logic [6:0] opc_load     = 7'b0000011;
    localparam logic [6:0] opc_store    = 7'b0100011;
    localparam logic [6:0] opc_system   = 7'b1110011;
    localparam logic [6:0] opc_misc_mem = 7'b0001111;

    // funct12 values of the privileged system instructions
    localparam logic [11:0] sys_ecall  = 12'h000;
    localparam logic [11:0] sys_ebreak = 12'h001;
    localparam logic [11:0] sys_mret   = 12'h302;

endpackage

/* verilog/pipe_pkg.sv */
package pipe_pkg;

    // control-flow vector carried from decode into execute
    typedef logic [11:0] ctrl_t;

    localparam int ctrl_lui       = 11;
    localparam int ctrl_csr_we    = 10;
    localparam int ctrl_jal       = 9;
    localparam int ctrl_fence     = 8;
    localparam int ctrl_jalr      = 7;
    localparam int ctrl_auipc     = 6;
    localparam int ctrl_branch    = 5;
    localparam int ctrl_alu_src   = 4;
    localparam int ctrl_mem_read  = 3;
    localparam int ctrl_mem_write = 2;
    localparam int ctrl_mem2reg   = 1;
    localparam int ctrl_write_reg = 0;

    // trap-type vector, bit 0 unused
    typedef logic [3:0] trap_t;

    localparam int trap_ecall  = 3;
    localparam int trap_ebreak = 2;
    localparam int trap_mret   = 1;

endpackage

/* verilog/id_decode.sv */
`timescale 1ns/100ps

module id_decode (
    input  isa_pkg::data_t    instruction,
    output pipe_pkg::ctrl_t   ctrl,
    output pipe_pkg::trap_t   trap,
    output isa_pkg::alu_op_e  alu_op,
    output isa_pkg::data_t    imm,
    output isa_pkg::reg_idx_t rs1_idx,
    output isa_pkg::reg_idx_t rs2_idx,
    output isa_pkg::reg_idx_t rd_idx
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic           funct7_b5;
    logic [3:0]     alu_code;
    isa_pkg::data_t imm_i;
    isa_pkg::data_t imm_s;
    isa_pkg::data_t imm_b;
    isa_pkg::data_t imm_u;
    isa_pkg::data_t imm_j;

    assign opcode    = instruction[6:0];
    assign funct3    = instruction[14:12];
    assign funct7_b5 = instruction[30];

    assign rs1_idx = instruction[19:15];
    assign rs2_idx = instruction[24:20];
    assign rd_idx  = instruction[11:7];

    // sign-extended immediate formats
    assign imm_i = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign imm_u = {instruction[31:12], 12'b0};
    assign imm_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    always_comb
    begin
        ctrl     = '0;
        trap     = '0;
        imm      = '0;
        alu_code = isa_pkg::alu_add;
        case (opcode)
            isa_pkg::opc_op:
            begin
                ctrl[pipe_pkg::ctrl_write_reg] = 1'b1;
                // only add/sub and srl/sra use funct7
                alu_code = {funct7_b5 && (funct3 == 3'b000 || funct3 == 3'b101), funct3};
            end
            isa_pkg::opc_op_imm:
            begin
                ctrl[pipe_pkg::ctrl_write_reg] = 1'b1;
                ctrl[pipe_pkg::ctrl_alu_src]   = 1'b1;
                imm      = imm_i;
                alu_code = {funct7_b5 && funct3 == 3'b101, funct3};
            end
            isa_pkg::opc_lui:
            begin
                ctrl[pipe_pkg::ctrl_write_reg] = 1'b1;
                ctrl[pipe_pkg::ctrl_lui]       = 1'b1;
                ctrl[pipe_pkg::ctrl_alu_src]   = 1'b1;
                imm      = imm_u;
                alu_code = isa_pkg::alu_pass_b;
            end
            isa_pkg::opc_auipc:
            begin
                ctrl[pipe_pkg::ctrl_write_reg] = 1'b1;
                ctrl[pipe_pkg::ctrl_auipc]     = 1'b1;
                ctrl[pipe_pkg::ctrl_alu_src]   = 1'b1;
                imm = imm_u;
            end
            isa_pkg::opc_jal:
            begin
                ctrl[pipe_pkg::ctrl_write_reg] = 1'b1;
                ctrl[pipe_pkg::ctrl_jal]       = 1'b1;
                imm = imm_j;
            end
            isa_pkg::opc_jalr:
            begin
                ctrl[pipe_pkg::ctrl_write_reg] = 1'b1;
                ctrl[pipe_pkg::ctrl_jalr]      = 1'b1;
                ctrl[pipe_pkg::ctrl_alu_src]   = 1'b1;
                imm = imm_i;
            end
            isa_pkg::opc_branch:
            begin
                ctrl[pipe_pkg::ctrl_branch] = 1'b1;
                imm      = imm_b;
                // branch funct3 rides in the low alu_op bits
                alu_code = {1'b0, funct3};
            end
            isa_pkg::opc_load:
            begin
                ctrl[pipe_pkg::ctrl_write_reg] = 1'b1;
                ctrl[pipe_pkg::ctrl_mem_read]  = 1'b1;
                ctrl[pipe_pkg::ctrl_mem2reg]   = 1'b1;
                ctrl[pipe_pkg::ctrl_alu_src]   = 1'b1;
                imm = imm_i;
            end
            isa_pkg::opc_store:
            begin
                ctrl[pipe_pkg::ctrl_mem_write] = 1'b1;
                ctrl[pipe_pkg::ctrl_alu_src]   = 1'b1;
                imm = imm_s;
            end
            isa_pkg::opc_misc_mem:
                ctrl[pipe_pkg::ctrl_fence] = 1'b1;
            isa_pkg::opc_system:
            begin
                if (funct3 != 3'b000)
                    ctrl[pipe_pkg::ctrl_csr_we] = 1'b1;
                else if (instruction[31:20] == isa_pkg::sys_ecall)
                    trap[pipe_pkg::trap_ecall] = 1'b1;
                else if (instruction[31:20] == isa_pkg::sys_ebreak)
                    trap[pipe_pkg::trap_ebreak] = 1'b1;
                else if (instruction[31:20] == isa_pkg::sys_mret)
                    trap[pipe_pkg::trap_mret] = 1'b1;
            end
            default:
                ctrl = '0;
        endcase
    end

    assign alu_op = isa_pkg::alu_op_e'(alu_code);

endmodule

/* verilog/id_ex.sv */
`timescale 1ns/100ps

module id_ex #(
    parameter int data_width
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    cancel,
    input  logic                    hold,
    input  logic                    allow_in_wb,
    input  logic                    allow_in_ex_commit,
    input  logic                    valid_id,
    input  logic                    ready_go_id,
    input  logic [data_width-1:0]   pc_id,
    input  logic [data_width-1:0]   rs1_data_id,
    input  logic [data_width-1:0]   rs2_data_id,
    input  logic [data_width-1:0]   imm_id,
    input  pipe_pkg::ctrl_t         ctrl_id,
    input  pipe_pkg::trap_t         trap_id,
    input  isa_pkg::alu_op_e        alu_op_id,
    input  isa_pkg::reg_idx_t       rs1_id,
    input  isa_pkg::reg_idx_t       rs2_id,
    input  isa_pkg::reg_idx_t       rd_id,
    output logic                    valid_ex,
    output logic                    ram_req,
    output logic [data_width-1:0]   pc_ex,
    output logic [data_width-1:0]   rs1_data_ex,
    output logic [data_width-1:0]   rs2_data_ex,
    output logic [data_width-1:0]   imm_ex,
    output isa_pkg::reg_idx_t       rs1_ex,
    output isa_pkg::reg_idx_t       rs2_ex,
    output isa_pkg::reg_idx_t       rd_ex,
    output pipe_pkg::ctrl_t         ctrl_ex,
    output pipe_pkg::trap_t         trap_ex,
    output isa_pkg::alu_op_e        alu_op_ex
);

    logic                  valid;
    logic                  pipe_valid;
    logic                  mem_access;
    logic [data_width-1:0] pc_q;
    logic [data_width-1:0] rs1_data_q;
    logic [data_width-1:0] rs2_data_q;
    logic [data_width-1:0] imm_q;
    isa_pkg::reg_idx_t     rs1_q;
    isa_pkg::reg_idx_t     rs2_q;
    isa_pkg::reg_idx_t     rd_q;
    pipe_pkg::ctrl_t       ctrl_q;
    pipe_pkg::trap_t       trap_q;
    isa_pkg::alu_op_e      alu_op_q;

    // an ID item is offered and not killed by a redirect
    assign pipe_valid = valid_id && ready_go_id && !flush;

    // cancel wins over the allow-in update
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            valid <= 1'b0;
        else if (cancel)
            valid <= 1'b0;
        else if (allow_in_ex_commit)
            valid <= pipe_valid;
    end

    // payload moves only on an accepted item
    always_ff @(posedge clk)
    begin
        if (pipe_valid && allow_in_ex_commit)
        begin
            pc_q       <= pc_id;
            rs1_data_q <= rs1_data_id;
            rs2_data_q <= rs2_data_id;
            imm_q      <= imm_id;
            rs1_q      <= rs1_id;
            rs2_q      <= rs2_id;
            rd_q       <= rd_id;
            ctrl_q     <= ctrl_id;
            trap_q     <= trap_id;
            alu_op_q   <= alu_op_id;
        end
    end

    assign valid_ex    = valid;
    assign pc_ex       = pc_q;
    assign rs1_data_ex = rs1_data_q;
    assign rs2_data_ex = rs2_data_q;
    assign imm_ex      = imm_q;
    assign rs1_ex      = rs1_q;
    assign rs2_ex      = rs2_q;
    assign rd_ex       = rd_q;

    // empty slot shows all-zero controls
    assign ctrl_ex   = ctrl_q & {$bits(pipe_pkg::ctrl_t){valid}};
    assign trap_ex   = trap_q & {$bits(pipe_pkg::trap_t){valid}};
    assign alu_op_ex = isa_pkg::alu_op_e'(alu_op_q & {$bits(isa_pkg::alu_op_e){valid}});

    // memory request only when the next stage can take it
    assign mem_access = ctrl_ex[pipe_pkg::ctrl_mem_read] || ctrl_ex[pipe_pkg::ctrl_mem_write];
    assign ram_req    = valid && mem_access && allow_in_wb && !hold;

endmodule

/* verilog/ex_stage.sv */
`timescale 1ns/100ps

module ex_stage #(
    parameter int data_width
) (
    input  logic                  valid_ex,
    input  logic                  ram_req,
    input  logic                  mem_addr_ok,
    input  logic                  hold,
    input  logic                  allow_in_wb,
    input  logic [data_width-1:0] pc_ex,
    input  logic [data_width-1:0] rs1_data_ex,
    input  logic [data_width-1:0] rs2_data_ex,
    input  logic [data_width-1:0] imm_ex,
    input  pipe_pkg::ctrl_t       ctrl_ex,
    input  isa_pkg::alu_op_e      alu_op_ex,
    output logic                  allow_in_ex_commit,
    output logic                  redirect,
    output logic [data_width-1:0] redirect_pc,
    output logic [data_width-1:0] result,
    output logic [data_width-1:0] ram_addr,
    output logic [data_width-1:0] ram_wdata,
    output logic                  ram_we,
    output logic                  write_reg
);

    localparam int shamt_w = $clog2(data_width);

    logic [data_width-1:0] op_b;
    logic [data_width-1:0] alu_out;
    logic [data_width-1:0] pc_plus_imm;
    logic [data_width-1:0] jalr_target;
    logic [shamt_w-1:0]    shamt;
    logic                  lt_s;
    logic                  lt_u;
    logic                  taken;
    logic                  mem_access;
    logic                  ready_go_ex;

    assign op_b  = ctrl_ex[pipe_pkg::ctrl_alu_src] ? imm_ex : rs2_data_ex;
    assign shamt = op_b[shamt_w-1:0];
    assign lt_s  = $signed(rs1_data_ex) < $signed(op_b);
    assign lt_u  = rs1_data_ex < op_b;

    always_comb
    begin
        case (alu_op_ex)
            isa_pkg::alu_add:    alu_out = rs1_data_ex + op_b;
            isa_pkg::alu_sub:    alu_out = rs1_data_ex - op_b;
            isa_pkg::alu_sll:    alu_out = rs1_data_ex << shamt;
            isa_pkg::alu_slt:    alu_out = {{(data_width-1){1'b0}}, lt_s};
            isa_pkg::alu_sltu:   alu_out = {{(data_width-1){1'b0}}, lt_u};
            isa_pkg::alu_xor:    alu_out = rs1_data_ex ^ op_b;
            isa_pkg::alu_srl:    alu_out = rs1_data_ex >> shamt;
            isa_pkg::alu_sra:    alu_out = $unsigned($signed(rs1_data_ex) >>> shamt);
            isa_pkg::alu_or:     alu_out = rs1_data_ex | op_b;
            isa_pkg::alu_and:    alu_out = rs1_data_ex & op_b;
            isa_pkg::alu_pass_b: alu_out = op_b;
            default:             alu_out = '0;
        endcase
    end

    // low alu_op bits hold the branch funct3
    always_comb
    begin
        case (alu_op_ex[2:0])
            3'b000:  taken = rs1_data_ex == rs2_data_ex;
            3'b001:  taken = rs1_data_ex != rs2_data_ex;
            3'b100:  taken = lt_s;
            3'b101:  taken = !lt_s;
            3'b110:  taken = lt_u;
            3'b111:  taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus_imm = pc_ex + imm_ex;
    assign jalr_target = (rs1_data_ex + imm_ex) & ~{{(data_width-1){1'b0}}, 1'b1};

    always_comb
    begin
        if (ctrl_ex[pipe_pkg::ctrl_jal] || ctrl_ex[pipe_pkg::ctrl_jalr])
            result = pc_ex + data_width'(4);
        else if (ctrl_ex[pipe_pkg::ctrl_lui])
            result = imm_ex;
        else if (ctrl_ex[pipe_pkg::ctrl_auipc])
            result = pc_plus_imm;
        else
            result = alu_out;
    end

    // controls arrive already gated by valid
    assign redirect = ctrl_ex[pipe_pkg::ctrl_jal] || ctrl_ex[pipe_pkg::ctrl_jalr] ||
                      (ctrl_ex[pipe_pkg::ctrl_branch] && taken);
    assign redirect_pc = ctrl_ex[pipe_pkg::ctrl_jalr] ? jalr_target : pc_plus_imm;

    assign ram_addr  = rs1_data_ex + imm_ex;
    assign ram_wdata = rs2_data_ex;
    assign ram_we    = ctrl_ex[pipe_pkg::ctrl_mem_write];
    assign write_reg = ctrl_ex[pipe_pkg::ctrl_write_reg];

    // memory items wait for the address handshake
    assign mem_access  = ctrl_ex[pipe_pkg::ctrl_mem_read] || ctrl_ex[pipe_pkg::ctrl_mem_write];
    assign ready_go_ex = !mem_access || (ram_req && mem_addr_ok);
    assign allow_in_ex_commit = !valid_ex || (ready_go_ex && allow_in_wb && !hold);

endmodule

/* verilog/id_ex_slice.sv */
`timescale 1ns/100ps

module id_ex_slice #(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [data_width-1:0] instruction,
    input  logic [data_width-1:0] pc,
    input  logic [data_width-1:0] rs1_data,
    input  logic [data_width-1:0] rs2_data,
    input  logic                  valid_id,
    input  logic                  ready_go_id,
    output logic                  allow_in_ex,
    input  logic                  hold,
    input  logic                  allow_in_wb,
    input  logic                  cancel,
    input  logic                  mem_addr_ok,
    output logic                  ram_req,
    output logic [data_width-1:0] ram_addr,
    output logic [data_width-1:0] ram_wdata,
    output logic                  ram_we,
    output logic [data_width-1:0] result,
    output isa_pkg::reg_idx_t     rd,
    output logic                  write_reg,
    output logic                  valid_ex,
    output logic                  redirect,
    output logic [data_width-1:0] redirect_pc,
    output logic                  ecall,
    output logic                  ebreak,
    output logic                  mret
);

    pipe_pkg::ctrl_t       ctrl_id;
    pipe_pkg::ctrl_t       ctrl_ex;
    pipe_pkg::trap_t       trap_id;
    pipe_pkg::trap_t       trap_ex;
    isa_pkg::alu_op_e      alu_op_id;
    isa_pkg::alu_op_e      alu_op_ex;
    isa_pkg::data_t        imm_id;
    isa_pkg::reg_idx_t     rs1_idx;
    isa_pkg::reg_idx_t     rs2_idx;
    isa_pkg::reg_idx_t     rd_idx;
    logic [data_width-1:0] pc_ex;
    logic [data_width-1:0] rs1_data_ex;
    logic [data_width-1:0] rs2_data_ex;
    logic [data_width-1:0] imm_ex;

    id_decode u_decode (
        .instruction (instruction),
        .ctrl        (ctrl_id),
        .trap        (trap_id),
        .alu_op      (alu_op_id),
        .imm         (imm_id),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rd_idx      (rd_idx)
    );

    // redirect doubles as the flush of the item entering from ID
    id_ex #(.data_width(data_width)) u_id_ex (
        .clk                (clk),
        .rst_n              (rst_n),
        .flush              (redirect),
        .cancel             (cancel),
        .hold               (hold),
        .allow_in_wb        (allow_in_wb),
        .allow_in_ex_commit (allow_in_ex),
        .valid_id           (valid_id),
        .ready_go_id        (ready_go_id),
        .pc_id              (pc),
        .rs1_data_id        (rs1_data),
        .rs2_data_id        (rs2_data),
        .imm_id             (imm_id),
        .ctrl_id            (ctrl_id),
        .trap_id            (trap_id),
        .alu_op_id          (alu_op_id),
        .rs1_id             (rs1_idx),
        .rs2_id             (rs2_idx),
        .rd_id              (rd_idx),
        .valid_ex           (valid_ex),
        .ram_req            (ram_req),
        .pc_ex              (pc_ex),
        .rs1_data_ex        (rs1_data_ex),
        .rs2_data_ex        (rs2_data_ex),
        .imm_ex             (imm_ex),
        .rs1_ex             (),
        .rs2_ex             (),
        .rd_ex              (rd),
        .ctrl_ex            (ctrl_ex),
        .trap_ex            (trap_ex),
        .alu_op_ex          (alu_op_ex)
    );

    ex_stage #(.data_width(data_width)) u_ex (
        .valid_ex           (valid_ex),
        .ram_req            (ram_req),
        .mem_addr_ok        (mem_addr_ok),
        .hold               (hold),
        .allow_in_wb        (allow_in_wb),
        .pc_ex              (pc_ex),
        .rs1_data_ex        (rs1_data_ex),
        .rs2_data_ex        (rs2_data_ex),
        .imm_ex             (imm_ex),
        .ctrl_ex            (ctrl_ex),
        .alu_op_ex          (alu_op_ex),
        .allow_in_ex_commit (allow_in_ex),
        .redirect           (redirect),
        .redirect_pc        (redirect_pc),
        .result             (result),
        .ram_addr           (ram_addr),
        .ram_wdata          (ram_wdata),
        .ram_we             (ram_we),
        .write_reg          (write_reg)
    );

    assign ecall  = trap_ex[pipe_pkg::trap_ecall];
    assign ebreak = trap_ex[pipe_pkg::trap_ebreak];
    assign mret   = trap_ex[pipe_pkg::trap_mret];

endmodule

/* dv/id_ex_slice_tb.sv */
`timescale 1ns/100ps

module id_ex_slice_tb;

    localparam int cycle_limit = 4000;

    // one ID item as the model keeps it
    typedef struct packed {
        isa_pkg::data_t w;
        isa_pkg::data_t pc;
        isa_pkg::data_t rs1;
        isa_pkg::data_t rs2;
    } item_t;

    localparam logic [6:0] opcode_table [0:10] = '{
        isa_pkg::opc_op, isa_pkg::opc_op_imm, isa_pkg::opc_lui, isa_pkg::opc_auipc,
        isa_pkg::opc_jal, isa_pkg::opc_jalr, isa_pkg::opc_branch, isa_pkg::opc_load,
        isa_pkg::opc_store, isa_pkg::opc_system, isa_pkg::opc_misc_mem
    };

    logic              clk;
    logic              rst_n;
    isa_pkg::data_t    instruction;
    isa_pkg::data_t    pc;
    isa_pkg::data_t    rs1_data;
    isa_pkg::data_t    rs2_data;
    logic              valid_id;
    logic              ready_go_id;
    logic              allow_in_ex;
    logic              hold;
    logic              allow_in_wb;
    logic              cancel;
    logic              mem_addr_ok;
    logic              ram_req;
    isa_pkg::data_t    ram_addr;
    isa_pkg::data_t    ram_wdata;
    logic              ram_we;
    isa_pkg::data_t    result;
    isa_pkg::reg_idx_t rd;
    logic              write_reg;
    logic              valid_ex;
    logic              redirect;
    isa_pkg::data_t    redirect_pc;
    logic              ecall;
    logic              ebreak;
    logic              mret;

    isa_pkg::data_t rng = 32'd41;
    int unsigned    cycle_count = 0;
    item_t          ex_q[$];
    item_t          m_item;
    logic           m_valid = 1'b0;
    logic [6:0]     m_opc;
    logic           is_mem;
    logic           exp_req;
    logic           exp_allow;
    logic           exp_wr;
    logic           exp_redirect;
    isa_pkg::data_t exp_target;
    logic [2:0]     exp_trap;

    id_ex_slice dut (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    task automatic stop_with_failure(input string what);
        $display("error at %0d ns: %s", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    function automatic isa_pkg::data_t next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic int rand_below(input int unsigned n);
        return int'(next_rand() % n);
    endfunction

    // slot 11 leaves the random opcode bits in place
    function automatic isa_pkg::data_t make_instr(input logic [11:0] kinds);
        int             idx;
        isa_pkg::data_t w;
        idx = rand_below(12);
        while (!kinds[idx])
            idx = rand_below(12);
        w = next_rand();
        if (idx < 11)
            w[6:0] = opcode_table[idx];
        if (idx == 9 && rand_below(4) != 0)
        begin
            w[14:12] = 3'b000;
            w[31:20] = (w[31:30] == 2'b00) ? isa_pkg::sys_mret : {11'b0, w[20]};
        end
        return w;
    endfunction

    function automatic isa_pkg::data_t imm_of(input isa_pkg::data_t w);
        case (w[6:0])
            isa_pkg::opc_op_imm, isa_pkg::opc_jalr, isa_pkg::opc_load:
                return {{20{w[31]}}, w[31:20]};
            isa_pkg::opc_store:
                return {{20{w[31]}}, w[31:25], w[11:7]};
            isa_pkg::opc_branch:
                return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            isa_pkg::opc_lui, isa_pkg::opc_auipc:
                return {w[31:12], 12'b0};
            isa_pkg::opc_jal:
                return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:
                return '0;
        endcase
    endfunction

    function automatic isa_pkg::data_t result_of(input item_t it);
        isa_pkg::data_t b;
        logic [4:0]     sh;
        logic           alt;
        b   = (it.w[6:0] == isa_pkg::opc_op) ? it.rs2 : imm_of(it.w);
        sh  = b[4:0];
        // sub only for R-type, sra for both shift forms
        alt = it.w[30] && (it.w[6:0] == isa_pkg::opc_op || it.w[14:12] == 3'b101);
        case (it.w[6:0])
            isa_pkg::opc_jal, isa_pkg::opc_jalr: return it.pc + 32'd4;
            isa_pkg::opc_lui:   return b;
            isa_pkg::opc_auipc: return it.pc + b;
            isa_pkg::opc_load:  return it.rs1 + b;
            default: ;
        endcase
        case (it.w[14:12])
            3'd0:    return alt ? it.rs1 - b : it.rs1 + b;
            3'd1:    return it.rs1 << sh;
            3'd2:    return {31'b0, $signed(it.rs1) < $signed(b)};
            3'd3:    return {31'b0, it.rs1 < b};
            3'd4:    return it.rs1 ^ b;
            3'd5:    return alt ? isa_pkg::data_t'($signed(it.rs1) >>> sh) : it.rs1 >> sh;
            3'd6:    return it.rs1 | b;
            default: return it.rs1 & b;
        endcase
    endfunction

    function automatic logic taken_of(input item_t it);
        case (it.w[14:12])
            3'd0:    return it.rs1 == it.rs2;
            3'd1:    return it.rs1 != it.rs2;
            3'd4:    return $signed(it.rs1) < $signed(it.rs2);
            3'd5:    return $signed(it.rs1) >= $signed(it.rs2);
            3'd6:    return it.rs1 < it.rs2;
            3'd7:    return it.rs1 >= it.rs2;
            default: return 1'b0;
        endcase
    endfunction

    // expected EX view of the model item
    assign m_opc     = m_item.w[6:0];
    assign is_mem    = m_opc == isa_pkg::opc_load || m_opc == isa_pkg::opc_store;
    assign exp_req   = m_valid && is_mem && allow_in_wb && !hold;
    assign exp_allow = !m_valid || ((!is_mem || (exp_req && mem_addr_ok)) && allow_in_wb && !hold);
    assign exp_wr    = m_valid && (m_opc inside {isa_pkg::opc_op, isa_pkg::opc_op_imm,
                       isa_pkg::opc_lui, isa_pkg::opc_auipc, isa_pkg::opc_jal,
                       isa_pkg::opc_jalr, isa_pkg::opc_load});
    assign exp_redirect = m_valid && (m_opc == isa_pkg::opc_jal || m_opc == isa_pkg::opc_jalr ||
                          (m_opc == isa_pkg::opc_branch && taken_of(m_item)));
    assign exp_target = (m_opc == isa_pkg::opc_jalr) ?
                        ((m_item.rs1 + imm_of(m_item.w)) & ~32'd1) : m_item.pc + imm_of(m_item.w);
    assign exp_trap = (m_valid && m_opc == isa_pkg::opc_system && m_item.w[14:12] == 3'b000) ?
                      {m_item.w[31:20] == 12'h000, m_item.w[31:20] == 12'h001,
                       m_item.w[31:20] == 12'h302} : 3'b000;

    // item accepted from ID, dropped on cancel or redirect
    always @(posedge clk)
    begin
        if (!rst_n || cancel)
            ex_q.delete();
        else if (exp_allow)
        begin
            ex_q.delete();
            if (valid_id && ready_go_id && !exp_redirect)
                ex_q.push_back({instruction, pc, rs1_data, rs2_data});
        end
        m_valid <= ex_q.size() != 0;
        if (ex_q.size() != 0)
            m_item <= ex_q[0];
    end

    assert property (@(posedge clk) disable iff (!rst_n) valid_ex == m_valid)
    else stop_with_failure("valid_ex differs from the model");
    assert property (@(posedge clk) disable iff (!rst_n) allow_in_ex == exp_allow)
    else stop_with_failure("allow_in_ex differs from the model");
    assert property (@(posedge clk) disable iff (!rst_n) ram_req == exp_req)
    else stop_with_failure("ram_req differs from the model");
    assert property (@(posedge clk) disable iff (!rst_n)
        ram_we == (m_valid && m_opc == isa_pkg::opc_store))
    else stop_with_failure("ram_we differs from the store bit");
    assert property (@(posedge clk) disable iff (!rst_n)
        !exp_req || (ram_addr == m_item.rs1 + imm_of(m_item.w) && ram_wdata == m_item.rs2))
    else stop_with_failure("memory address or write data is wrong");
    assert property (@(posedge clk) disable iff (!rst_n) write_reg == exp_wr)
    else stop_with_failure("write_reg differs from the model");
    assert property (@(posedge clk) disable iff (!rst_n)
        !exp_wr || (result == result_of(m_item) && rd == m_item.w[11:7]))
    else stop_with_failure("result or rd is wrong");
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect == exp_redirect && (!exp_redirect || redirect_pc == exp_target))
    else stop_with_failure("redirect or redirect_pc is wrong");
    assert property (@(posedge clk) disable iff (!rst_n) {ecall, ebreak, mret} == exp_trap)
    else stop_with_failure("trap flags differ from the model");
    // a stalled item keeps its outputs
    assert property (@(posedge clk) disable iff (!rst_n)
        m_valid && !exp_allow && !cancel |=> valid_ex && $stable(result) && $stable(rd) &&
        $stable(ram_addr))
    else stop_with_failure("EX item changed while stalled");

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    initial
    begin
        wait (cycle_count == cycle_limit);
        stop_with_failure("timeout, the run did not finish within the cycle limit");
    end

    // kinds selects opcode slots, bp/nak/kill are percentages
    task automatic run_phase(input int cycles, input logic [11:0] kinds, input int bp,
                             input int nak, input int kill);
        repeat (cycles)
        begin
            @(posedge clk);
            #1;
            valid_id    = rand_below(8) != 0;
            ready_go_id = rand_below(8) != 0;
            instruction = make_instr(kinds);
            pc          = next_rand() & ~32'd3;
            rs1_data    = next_rand();
            rs2_data    = (rand_below(4) == 0) ? rs1_data : next_rand();
            hold        = rand_below(100) < bp;
            allow_in_wb = rand_below(100) >= bp;
            mem_addr_ok = rand_below(100) >= nak;
            cancel      = rand_below(100) < kill;
        end
    endtask

    initial
    begin
        rst_n       = 1'b0;
        instruction = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        valid_id    = 1'b0;
        ready_go_id = 1'b0;
        hold        = 1'b0;
        allow_in_wb = 1'b1;
        cancel      = 1'b0;
        mem_addr_ok = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (4) @(posedge clk);
        run_phase(400, 12'h00F, 0, 0, 0);
        run_phase(400, 12'h180, 0, 50, 0);
        run_phase(400, 12'h18F, 30, 0, 0);
        run_phase(400, 12'h070, 0, 0, 0);
        run_phase(400, 12'hE0F, 0, 0, 10);
        run_phase(400, 12'hFFF, 20, 30, 5);
        run_phase(400, 12'h1F0, 25, 25, 0);
        run_phase(400, 12'hFFF, 10, 10, 10);
        @(posedge clk);
        #1;
        valid_id    = 1'b0;
        hold        = 1'b0;
        allow_in_wb = 1'b1;
        mem_addr_ok = 1'b1;
        cancel      = 1'b0;
        repeat (8) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* id_ex_slice.f */
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/id_decode.sv
verilog/id_ex.sv
verilog/ex_stage.sv
verilog/id_ex_slice.sv
dv/id_ex_slice_tb.sv
